/* verilog.f */
verilog/pad_pkg.sv
verilog/clk_rst_pkg.sv
verilog/pad_control.sv
verilog/rst_gen.sv
verilog/slow_clk_gen.sv
verilog/safe_domain.sv
tb/safe_domain_checker.sv
tb/safe_domain_tb.sv

/* Bender.yml */
package:
  name: safe_domain

sources:
  - verilog/pad_pkg.sv
  - verilog/clk_rst_pkg.sv
  - verilog/pad_control.sv
  - verilog/rst_gen.sv
  - verilog/slow_clk_gen.sv
  - verilog/safe_domain.sv
  - target: test
    files:
      - tb/safe_domain_checker.sv
      - tb/safe_domain_tb.sv

/* tb/safe_domain_tb.sv */
`default_nettype none
`timescale 1ns/10ps

module safe_domain_tb
  import pad_pkg::*;
  import clk_rst_pkg::*;
();

  localparam int N_IO            = 8;
  localparam int RST_HOLD_CYCLES = 4;
  localparam int SLOW_DIV        = 5;
  localparam int EFPGA_DIV       = 2;

  // everything the pad routing should show
  typedef struct packed {
    pad_drive_t [N_IO-1:0] drive;
    pad_cfg_t   [N_IO-1:0] cfg;
    logic       [N_IO-1:0] perio_in;
    logic       [N_IO-1:0] gpio_in;
    logic       [N_IO-1:0] fpgaio_in;
  } pad_exp_t;

  logic                  ref_clk_i = 1'b0;
  logic                  rst_i;
  logic                  rst_o;
  logic                  slow_clk_o;
  logic                  efpga_clk_o;
  pad_mux_e   [N_IO-1:0] pad_mux_i;
  pad_cfg_t   [N_IO-1:0] pad_cfg_i;
  pad_cfg_t   [N_IO-1:0] pad_cfg_o;
  pad_drive_t [N_IO-1:0] perio_drive_i;
  pad_drive_t [N_IO-1:0] gpio_drive_i;
  pad_drive_t [N_IO-1:0] fpgaio_drive_i;
  pad_drive_t [N_IO-1:0] io_drive_o;
  logic       [N_IO-1:0] io_in_i;
  logic       [N_IO-1:0] perio_in_o;
  logic       [N_IO-1:0] gpio_in_o;
  logic       [N_IO-1:0] fpgaio_in_o;
  pad_exp_t              want;
  int                    low_cnt = 0;
  int                    errors = 0;
  int                    checks = 0;
  int                    tests_ok = 0;
  int                    tests_bad = 0;

  safe_domain #(
    .N_IO            (N_IO),
    .RST_HOLD_CYCLES (RST_HOLD_CYCLES),
    .SLOW_DIV        (DIV_W'(SLOW_DIV)),
    .EFPGA_DIV       (DIV_W'(EFPGA_DIV))
  ) DUT (.*);

  // ********************
  // clock and stimulus
  // ********************
  always #10 ref_clk_i = ~ref_clk_i;

  // new random pad side every cycle
  always @(posedge ref_clk_i) begin
    for (int k = 0; k < N_IO; k++) begin
      pad_mux_i[k]      <= pad_mux_e'($urandom_range(3));
      pad_cfg_i[k]      <= pad_cfg_t'($urandom_range(63));
      perio_drive_i[k]  <= pad_drive_t'($urandom_range(3));
      gpio_drive_i[k]   <= pad_drive_t'($urandom_range(3));
      fpgaio_drive_i[k] <= pad_drive_t'($urandom_range(3));
      io_in_i[k]        <= 1'($urandom_range(1));
    end
  end

  // saturating count of edges with rst_i low
  always @(posedge ref_clk_i) begin
    if (rst_i) begin
      low_cnt <= 0;
    end else if (low_cnt <= RST_HOLD_CYCLES) begin
      low_cnt <= low_cnt + 1;
    end
  end

  // ********************
  // reference and checks
  // ********************
  function automatic pad_exp_t pad_expect(input logic in_rst);
    pad_exp_t   e;
    pad_drive_t src;
    e = '0;
    for (int k = 0; k < N_IO; k++) begin
      // off pads select no source
      src = (pad_mux_i[k] == MUX_PERIO)  ? perio_drive_i[k] :
            (pad_mux_i[k] == MUX_GPIO)   ? gpio_drive_i[k] :
            (pad_mux_i[k] == MUX_FPGAIO) ? fpgaio_drive_i[k] : pad_drive_t'('0);
      e.drive[k]     = in_rst ? pad_drive_t'('0) : src;
      e.cfg[k]       = in_rst ? PAD_CFG_SAFE : pad_cfg_i[k];
      // input goes only to the owning function even in reset
      e.perio_in[k]  = io_in_i[k] && (pad_mux_i[k] == MUX_PERIO);
      e.gpio_in[k]   = io_in_i[k] && (pad_mux_i[k] == MUX_GPIO);
      e.fpgaio_in[k] = io_in_i[k] && (pad_mux_i[k] == MUX_FPGAIO);
    end
    return e;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp_val);
    checks++;
    assert (got === exp_val) else begin
      errors++;
      $display("CHECK FAILED t=%0t %s expected=%h actual=%h", $time, name, exp_val, got);
    end
  endtask

  // mid-cycle compare with inputs settled since the rising edge
  always @(negedge ref_clk_i) begin
    want = pad_expect(low_cnt <= RST_HOLD_CYCLES);
    check_value("rst_o", rst_o, low_cnt <= RST_HOLD_CYCLES);
    check_value("io_drive_o", io_drive_o, want.drive);
    check_value("pad_cfg_o", pad_cfg_o, want.cfg);
    check_value("perio_in_o", perio_in_o, want.perio_in);
    check_value("gpio_in_o", gpio_in_o, want.gpio_in);
    check_value("fpgaio_in_o", fpgaio_in_o, want.fpgaio_in);
  end

  task automatic report_test(input string name, input int err_mark);
    if (errors == err_mark) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, errors - err_mark);
    end
  endtask

  // held edges counted from the first edge with rst_i low
  task automatic check_release();
    int held;
    held = 0;
    while (held <= RST_HOLD_CYCLES + 4) begin
      @(posedge ref_clk_i);
      @(negedge ref_clk_i);
      if (rst_o !== 1'b1) begin
        break;
      end
      held++;
    end
    if (rst_o === 1'b1) begin
      errors++;
      $display("timeout: rst_o was never released after rst_i fell");
    end else begin
      check_value("rst_o hold edges", held, RST_HOLD_CYCLES);
    end
  endtask

  function automatic logic clk_level(input logic use_efpga);
    return use_efpga ? efpga_clk_o : slow_clk_o;
  endfunction

  // spacing of six toggles after syncing to one
  task automatic check_spacing(input logic use_efpga, input int div, input string name);
    logic prev;
    int   gap;
    @(negedge ref_clk_i);
    prev = clk_level(use_efpga);
    for (int t = 0; t < 7; t++) begin
      gap = 0;
      do begin
        @(negedge ref_clk_i);
        gap++;
      end while (clk_level(use_efpga) === prev && gap < 4 * div + 8);
      if (clk_level(use_efpga) === prev) begin
        errors++;
        $display("timeout: %s stopped toggling", name);
        return;
      end
      // first gap only syncs
      if (t > 0) begin
        check_value({name, " toggle spacing"}, gap, div);
      end
      prev = clk_level(use_efpga);
    end
  endtask

  // ********************
  // test sequence
  // ********************
  initial begin
    int err_mark;
    void'($urandom(71011));
    rst_i          = 1'b1;
    pad_mux_i      = '0;
    pad_cfg_i      = '0;
    perio_drive_i  = '0;
    gpio_drive_i   = '0;
    fpgaio_drive_i = '0;
    io_in_i        = '0;

    // pads stay safe under random drives during the hold
    err_mark = errors;
    repeat (8) @(posedge ref_clk_i);
    rst_i <= 1'b0;
    check_release();
    report_test("reset release", err_mark);

    err_mark = errors;
    repeat (200) @(posedge ref_clk_i);
    report_test("random routing", err_mark);

    // off pads feed no function
    err_mark = errors;
    repeat (100) begin
      @(negedge ref_clk_i);
      for (int k = 0; k < N_IO; k++) begin
        if (pad_mux_i[k] == MUX_OFF) begin
          check_value("inputs of off pad", {perio_in_o[k], gpio_in_o[k], fpgaio_in_o[k]}, '0);
        end
      end
    end
    report_test("input steering", err_mark);

    err_mark = errors;
    check_spacing(1'b0, SLOW_DIV, "slow_clk_o");
    check_spacing(1'b1, EFPGA_DIV, "efpga_clk_o");
    report_test("clock division", err_mark);

    // rst_i sampled high on three edges
    err_mark = errors;
    @(posedge ref_clk_i);
    rst_i <= 1'b1;
    @(posedge ref_clk_i);
    @(negedge ref_clk_i);
    check_value("rst_o after mid-run reset", rst_o, 1'b1);
    check_value("io_drive_o in mid-run reset", io_drive_o, '0);
    @(posedge ref_clk_i);
    @(negedge ref_clk_i);
    check_value("slow_clk_o in reset", slow_clk_o, 1'b0);
    check_value("efpga_clk_o in reset", efpga_clk_o, 1'b0);
    @(posedge ref_clk_i);
    rst_i <= 1'b0;
    check_release();
    report_test("mid-run reset", err_mark);

    $display("tests ok=%0d bad=%0d, checks=%0d errors=%0d", tests_ok, tests_bad, checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // overall limit on run time
  initial begin
    #2_000_000;
    $display("watchdog expired before the test sequence finished");
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb/safe_domain_checker.sv */
`default_nettype none
`timescale 1ns/10ps

module safe_domain_checker
  import pad_pkg::*;
  import clk_rst_pkg::*;
#(
  parameter int unsigned N_IO = 8
) (
  input logic                  clk_i,
  input logic                  ext_rst_i,
  input logic                  dom_rst_i,
  input logic                  slow_clk_i,
  input pad_drive_t [N_IO-1:0] io_drive_i,
  input rst_state_e            rst_state_i
);

  logic [N_IO-1:0] oe_bits;

  // output enables of all pads
  always_comb begin
    for (int k = 0; k < N_IO; k++) begin
      oe_bits[k] = io_drive_i[k].oe;
    end
  end

  // ********************
  // reset and pad safety
  // ********************

  // registered reset follows the external one
  a_rst_follows: assert property (@(posedge clk_i) ext_rst_i |=> dom_rst_i)
    else $error("domain reset did not follow external reset");

  // no pad driven during domain reset
  a_pads_off: assert property (@(posedge clk_i) dom_rst_i |-> (oe_bits == '0))
    else $error("pad output enabled during domain reset");

  // divider is cleared one edge after the domain reset
  a_slow_clk_low: assert property (@(posedge clk_i) dom_rst_i |=> !slow_clk_i)
    else $error("slow clock high during domain reset");

  a_done_released: assert property (@(posedge clk_i) (rst_state_i == RST_DONE) |-> !dom_rst_i)
    else $error("domain reset still high in done state");

endmodule

// attached to every safe_domain instance
bind safe_domain safe_domain_checker #(
  .N_IO (N_IO)
) i_checker (
  .clk_i       (ref_clk_i),
  .ext_rst_i   (rst_i),
  .dom_rst_i   (rst_o),
  .slow_clk_i  (slow_clk_o),
  .io_drive_i  (io_drive_o),
  .rst_state_i (i_rst_gen.state_q)
);

`default_nettype wire

/* verilog/safe_domain.sv */
`default_nettype none
`timescale 1ns/10ps

module safe_domain
  import pad_pkg::*;
  import clk_rst_pkg::*;
#(
  parameter int unsigned      N_IO            = 8,
  parameter int unsigned      RST_HOLD_CYCLES = 4,
  parameter logic [DIV_W-1:0] SLOW_DIV        = DIV_W'(5),
  parameter logic [DIV_W-1:0] EFPGA_DIV       = DIV_W'(2)
) (
  input  logic                   ref_clk_i,
  input  logic                   rst_i,
  // domain reset, also for the rest of the SoC
  output logic                   rst_o,

  output logic                   slow_clk_o,
  output logic                   efpga_clk_o,

  // ********************
  // pad control
  // ********************
  input  pad_mux_e   [N_IO-1:0]  pad_mux_i,
  input  pad_cfg_t   [N_IO-1:0]  pad_cfg_i,
  output pad_cfg_t   [N_IO-1:0]  pad_cfg_o,

  input  pad_drive_t [N_IO-1:0]  perio_drive_i,
  input  pad_drive_t [N_IO-1:0]  gpio_drive_i,
  input  pad_drive_t [N_IO-1:0]  fpgaio_drive_i,

  output pad_drive_t [N_IO-1:0]  io_drive_o,
  input  logic       [N_IO-1:0]  io_in_i,

  output logic       [N_IO-1:0]  perio_in_o,
  output logic       [N_IO-1:0]  gpio_in_o,
  output logic       [N_IO-1:0]  fpgaio_in_o
);

  // stretched reset for the whole domain
  rst_gen #(
    .RST_HOLD_CYCLES (RST_HOLD_CYCLES)
  ) i_rst_gen (
    .ref_clk_i (ref_clk_i),
    .rst_i     (rst_i),
    .rst_o     (rst_o)
  );

  // pad routing, tri-stated during domain reset
  pad_control #(
    .N_IO (N_IO)
  ) i_pad_control (
    .rst_i          (rst_o),
    .pad_mux_i      (pad_mux_i),
    .pad_cfg_i      (pad_cfg_i),
    .pad_cfg_o      (pad_cfg_o),
    .perio_drive_i  (perio_drive_i),
    .gpio_drive_i   (gpio_drive_i),
    .fpgaio_drive_i (fpgaio_drive_i),
    .io_drive_o     (io_drive_o),
    .io_in_i        (io_in_i),
    .perio_in_o     (perio_in_o),
    .gpio_in_o      (gpio_in_o),
    .fpgaio_in_o    (fpgaio_in_o)
  );

  // slow and efpga clocks from ref clock
  slow_clk_gen #(
    .SLOW_DIV  (SLOW_DIV),
    .EFPGA_DIV (EFPGA_DIV)
  ) i_slow_clk_gen (
    .ref_clk_i   (ref_clk_i),
    .rst_i       (rst_o),
    .slow_clk_o  (slow_clk_o),
    .efpga_clk_o (efpga_clk_o)
  );

endmodule

`default_nettype wire

/* verilog/slow_clk_gen.sv */
`default_nettype none
`timescale 1ns/10ps

module slow_clk_gen
  import clk_rst_pkg::*;
#(
  parameter logic [DIV_W-1:0] SLOW_DIV  = DIV_W'(5),
  parameter logic [DIV_W-1:0] EFPGA_DIV = DIV_W'(2)
) (
  input  logic ref_clk_i,
  input  logic rst_i,
  output logic slow_clk_o,
  output logic efpga_clk_o
);

  // channel index per divider
  localparam int unsigned CH_SLOW  = 0;
  localparam int unsigned CH_EFPGA = 1;
  localparam int unsigned N_CH     = 2;

  // terminal count per channel
  localparam logic [N_CH-1:0][DIV_W-1:0] DIV_LAST = {
    EFPGA_DIV - DIV_W'(1),
    SLOW_DIV  - DIV_W'(1)
  };

  logic [N_CH-1:0][DIV_W-1:0] cnt_q;
  logic [N_CH-1:0]            clk_q;

  // ********************
  // toggle dividers
  // ********************
  always_ff @(posedge ref_clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
      clk_q <= '0;
    end else begin
      for (int unsigned k = 0; k < N_CH; k++) begin
        // toggle on terminal count, then wrap
        if (cnt_q[k] == DIV_LAST[k]) begin
          cnt_q[k] <= '0;
          clk_q[k] <= ~clk_q[k];
        end else begin
          cnt_q[k] <= cnt_q[k] + 1'b1;
        end
      end
    end
  end

  // straight from flops, no glitches
  assign slow_clk_o  = clk_q[CH_SLOW];
  assign efpga_clk_o = clk_q[CH_EFPGA];

endmodule

`default_nettype wire

/* verilog/rst_gen.sv */
`default_nettype none
`timescale 1ns/10ps

module rst_gen
  import clk_rst_pkg::*;
#(
  parameter int unsigned RST_HOLD_CYCLES = 4
) (
  input  logic ref_clk_i,
  input  logic rst_i,
  output logic rst_o
);

  // hold counter sized for the last hold count
  localparam int unsigned CNT_W = (RST_HOLD_CYCLES > 1) ? $clog2(RST_HOLD_CYCLES) : 1;
  localparam logic [CNT_W-1:0] HOLD_LAST = CNT_W'(RST_HOLD_CYCLES - 1);

  rst_state_e       state_q;
  rst_state_e       state_d;
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_d;

  // ********************
  // next state
  // ********************
  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      // first edge with ext reset low
      RST_ASSERT: begin
        state_d = RST_HOLD;
        cnt_d   = '0;
      end
      // count hold edges
      RST_HOLD: begin
        if (cnt_q == HOLD_LAST) begin
          state_d = RST_DONE;
        end else begin
          cnt_d = cnt_q + 1'b1;
        end
      end
      RST_DONE: state_d = RST_DONE;
      default:  state_d = RST_ASSERT;
    endcase
  end

  // ********************
  // registers
  // ********************
  always_ff @(posedge ref_clk_i) begin
    if (rst_i) begin
      state_q <= RST_ASSERT;
      cnt_q   <= '0;
      rst_o   <= 1'b1;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      // released together with the move to done
      rst_o   <= (state_d != RST_DONE);
    end
  end

endmodule

`default_nettype wire

/* verilog/pad_control.sv */
`default_nettype none
`timescale 1ns/10ps

module pad_control
  import pad_pkg::*;
#(
  parameter int unsigned N_IO = 8
) (
  input  logic                   rst_i,

  // ********************
  // mux and config
  // ********************
  input  pad_mux_e   [N_IO-1:0]  pad_mux_i,
  input  pad_cfg_t   [N_IO-1:0]  pad_cfg_i,
  output pad_cfg_t   [N_IO-1:0]  pad_cfg_o,

  // ********************
  // functional sources
  // ********************
  input  pad_drive_t [N_IO-1:0]  perio_drive_i,
  input  pad_drive_t [N_IO-1:0]  gpio_drive_i,
  input  pad_drive_t [N_IO-1:0]  fpgaio_drive_i,

  // ********************
  // pad side
  // ********************
  output pad_drive_t [N_IO-1:0]  io_drive_o,
  input  logic       [N_IO-1:0]  io_in_i,

  // returned pad inputs, per function
  output logic       [N_IO-1:0]  perio_in_o,
  output logic       [N_IO-1:0]  gpio_in_o,
  output logic       [N_IO-1:0]  fpgaio_in_o
);

  // one slice of routing per pad
  for (genvar i = 0; i < N_IO; i++) begin : g_pad
    pad_drive_t drive_sel;
    logic       sel_perio;
    logic       sel_gpio;
    logic       sel_fpgaio;

    // pick drive pair and the one function that owns the pad
    always_comb begin
      drive_sel  = '0;
      sel_perio  = 1'b0;
      sel_gpio   = 1'b0;
      sel_fpgaio = 1'b0;
      unique case (pad_mux_i[i])
        MUX_PERIO: begin
          drive_sel = perio_drive_i[i];
          sel_perio = 1'b1;
        end
        MUX_GPIO: begin
          drive_sel = gpio_drive_i[i];
          sel_gpio  = 1'b1;
        end
        MUX_FPGAIO: begin
          drive_sel  = fpgaio_drive_i[i];
          sel_fpgaio = 1'b1;
        end
        MUX_OFF: begin
          // pad parked, out 0 and oe 0
          drive_sel = '0;
        end
        default: begin
          drive_sel = '0;
        end
      endcase
    end

    // reset override: tri-state and safe config
    assign io_drive_o[i] = rst_i ? pad_drive_t'('0) : drive_sel;
    assign pad_cfg_o[i]  = rst_i ? PAD_CFG_SAFE : pad_cfg_i[i];

    // inputs stay routed in reset
    // non-selected functions see 0
    assign perio_in_o[i]  = sel_perio  & io_in_i[i];
    assign gpio_in_o[i]   = sel_gpio   & io_in_i[i];
    assign fpgaio_in_o[i] = sel_fpgaio & io_in_i[i];
  end

endmodule

`default_nettype wire

/* verilog/clk_rst_pkg.sv */
`default_nettype none

package clk_rst_pkg;

  // ********************
  // reset generator
  // ********************

  // assert while ext reset high, hold after release, then done
  typedef enum logic [1:0] {
    RST_ASSERT = 2'd0,
    RST_HOLD   = 2'd1,
    RST_DONE   = 2'd2
  } rst_state_e;

  // ********************
  // clock dividers
  // ********************

  // width of divider counters and divider values
  localparam int unsigned DIV_W = 16;

endpackage

`default_nettype wire

/* verilog/pad_pkg.sv */
`default_nettype none

package pad_pkg;

  // ********************
  // pad source select
  // ********************

  // one value per functional source, plus pad off
  typedef enum logic [1:0] {
    MUX_PERIO  = 2'd0,
    MUX_GPIO   = 2'd1,
    MUX_FPGAIO = 2'd2,
    MUX_OFF    = 2'd3
  } pad_mux_e;

  // ********************
  // pad configuration
  // ********************

  // electrical settings seen by the pad cell
  typedef struct packed {
    logic [1:0] drv;    // drive strength
    logic       pu_en;  // pull-up
    logic       pd_en;  // pull-down
    logic       st_en;  // schmitt trigger
    logic       slew;   // slew control
  } pad_cfg_t;

  // everything off while the domain is in reset
  localparam pad_cfg_t PAD_CFG_SAFE = '0;

  // one pad output value and its enable
  typedef struct packed {
    logic out;
    logic oe;
  } pad_drive_t;

endpackage

`default_nettype wire
